/* src/ps2_pkg.sv */
package ps2_pkg;

    // Scan code bytes with a fixed meaning in set 2
    localparam logic [7:0] SCAN_INIT   = 8'hAA;
    localparam logic [7:0] SCAN_EXTEND = 8'hE0;
    localparam logic [7:0] SCAN_BREAK  = 8'hF0;

    // One bit per {extend, code} pair
    localparam int KEY_MAP_W = 512;

    // System cycles without a PS/2 clock edge before a partial frame is dropped
    localparam int RX_TIMEOUT = 4096;

    // Event buffer entries
    localparam int QUEUE_DEPTH = 8;

    // Slots in the consumer's buffer, which is also the credit count after reset
    localparam int CREDIT_INIT = 4;

    // A key change seen two ways
    // The decoder builds it from prefix flags and the code byte
    // The key map and the consumer treat {ext, code} as one key number
    typedef union packed {
        struct packed {
            logic       brk;
            logic       ext;
            logic [7:0] code;
        } fields;
        struct packed {
            logic       brk;
            logic [8:0] index;
        } map;
    } key_event_u;

endpackage

/* src/ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_error
);
    import ps2_pkg::*;

    localparam int IDLE_W = $clog2(RX_TIMEOUT + 1);

    logic [1:0]        clk_sync;
    logic [1:0]        data_sync;
    logic              clk_prev;
    logic              fall;
    logic [9:0]        shift;
    logic [10:0]       frame;
    logic [3:0]        bit_cnt;
    logic [IDLE_W-1:0] idle_cnt;
    logic              timeout;
    logic              frame_done;
    logic              frame_ok;

    // Both lines idle high, so the synchronizers come out of reset at one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    // The device changes data on the rising edge, so it is stable at the fall
    assign fall = clk_prev & ~clk_sync[1];

    // Bits arrive LSB first, so each new bit enters at the top
    assign frame = {data_sync[1], shift};

    assign frame_done = fall && (bit_cnt == 4'd10);

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

    assign timeout = (bit_cnt != 4'd0) && !fall &&
                     (idle_cnt == IDLE_W'(RX_TIMEOUT - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt     <= 4'd0;
            idle_cnt    <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (frame_done) begin
                    bit_cnt     <= 4'd0;
                    rx_valid    <= frame_ok;
                    frame_error <= !frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (timeout) begin
                // Device stopped mid-frame, start over on the next edge
                bit_cnt     <= 4'd0;
                idle_cnt    <= '0;
                frame_error <= 1'b1;
            end else if (bit_cnt != 4'd0) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) begin
            shift <= frame[10:1];
        end
        if (frame_done) begin
            rx_byte <= frame[8:1];
        end
    end

endmodule

/* src/scan_decoder.sv */
`timescale 1ns/1ps

module scan_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           rx_byte,
    input  logic                 rx_valid,
    output ps2_pkg::key_event_u  dec_event,
    output logic                 dec_valid
);
    import ps2_pkg::*;

    logic ready;
    logic pend_ext;
    logic pend_brk;
    logic is_init;
    logic is_extend;
    logic is_break;
    logic emit;

    assign is_init   = (rx_byte == SCAN_INIT);
    assign is_extend = (rx_byte == SCAN_EXTEND);
    assign is_break  = (rx_byte == SCAN_BREAK);

    // A plain code byte closes whatever prefix sequence came before it
    assign emit = rx_valid && ready && !is_init && !is_extend && !is_break;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready     <= 1'b0;
            pend_ext  <= 1'b0;
            pend_brk  <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= emit;
            if (rx_valid) begin
                if (is_init) begin
                    // Self-test pass, also seen again after a keyboard reset
                    ready    <= 1'b1;
                    pend_ext <= 1'b0;
                    pend_brk <= 1'b0;
                end else if (ready) begin
                    if (is_extend) begin
                        pend_ext <= 1'b1;
                    end else if (is_break) begin
                        pend_brk <= 1'b1;
                    end else begin
                        pend_ext <= 1'b0;
                        pend_brk <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            dec_event.fields.brk  <= pend_brk;
            dec_event.fields.ext  <= pend_ext;
            dec_event.fields.code <= rx_byte;
        end
    end

    // Frames are hundreds of cycles apart, so events can never be back to back
    a_dec_single: assert property (
        @(posedge clk) disable iff (rst)
        dec_valid |=> !dec_valid
    );

endmodule

/* src/key_state.sv */
`timescale 1ns/1ps

module key_state (
    input  logic                          clk,
    input  logic                          rst,
    input  ps2_pkg::key_event_u           dec_event,
    input  logic                          dec_valid,
    output logic [ps2_pkg::KEY_MAP_W-1:0] key_down,
    output ps2_pkg::key_event_u           chg_event,
    output logic                          chg_valid
);
    import ps2_pkg::*;

    logic [8:0] idx;
    logic       brk;
    logic       change;

    assign idx = dec_event.map.index;
    assign brk = dec_event.map.brk;

    // Only a make of an up key or a break of a down key changes the map
    assign change = dec_valid && (brk == key_down[idx]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_down  <= '0;
            chg_valid <= 1'b0;
        end else begin
            chg_valid <= change;
            if (change) begin
                key_down[idx] <= !brk;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (change) begin
            chg_event <= dec_event;
        end
    end

    a_flip_one: assert property (
        @(posedge clk) disable iff (rst)
        chg_valid |-> ((key_down ^ $past(key_down)) ==
                       (KEY_MAP_W'(1) << chg_event.map.index)) &&
                      (key_down[chg_event.map.index] == !chg_event.map.brk)
    );

endmodule

/* src/key_event_queue.sv */
`timescale 1ns/1ps

module key_event_queue (
    input  logic                clk,
    input  logic                rst,
    input  ps2_pkg::key_event_u chg_event,
    input  logic                chg_valid,
    output ps2_pkg::key_event_u out_event,
    output logic                out_valid,
    input  logic                credit_return,
    output logic                overrun
);
    import ps2_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = $clog2(CREDIT_INIT + 1);

    key_event_u       mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             rd_en;

    assign full  = (count == CNT_W'(QUEUE_DEPTH));
    assign empty = (count == '0);
    assign wr_en = chg_valid && !full;

    // Head is offered only when the consumer has room for it
    assign out_valid = !empty && (credits != '0);
    assign out_event = mem[rd_ptr];
    assign rd_en     = out_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRD_W'(CREDIT_INIT);
            overrun <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({rd_en, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if (chg_valid && full) begin
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= chg_event;
        end
    end

    // The consumer must never hand back more slots than it was given
    a_credit_max: assert property (
        @(posedge clk) disable iff (rst)
        credits <= CRD_W'(CREDIT_INIT)
    );

    a_credit_spend: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> (credits != '0)
    );

endmodule

/* src/ps2_keyboard_top.sv */
`timescale 1ns/1ps

module ps2_keyboard_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ps2_clk,
    input  logic                          ps2_data,
    output logic [ps2_pkg::KEY_MAP_W-1:0] key_down,
    output ps2_pkg::key_event_u           out_event,
    output logic                          out_valid,
    input  logic                          credit_return,
    output logic                          frame_error,
    output logic                          overrun
);
    import ps2_pkg::*;

    logic [7:0] rx_byte;
    logic       rx_valid;
    key_event_u dec_event;
    logic       dec_valid;
    key_event_u chg_event;
    logic       chg_valid;

    ps2_rx ps2_rx_i (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_error (frame_error)
    );

    scan_decoder scan_decoder_i (
        .clk       (clk),
        .rst       (rst),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .dec_event (dec_event),
        .dec_valid (dec_valid)
    );

    key_state key_state_i (
        .clk       (clk),
        .rst       (rst),
        .dec_event (dec_event),
        .dec_valid (dec_valid),
        .key_down  (key_down),
        .chg_event (chg_event),
        .chg_valid (chg_valid)
    );

    key_event_queue key_event_queue_i (
        .clk           (clk),
        .rst           (rst),
        .chg_event     (chg_event),
        .chg_valid     (chg_valid),
        .out_event     (out_event),
        .out_valid     (out_valid),
        .credit_return (credit_return),
        .overrun       (overrun)
    );

endmodule

/* sim/tb_ps2_tasks.svh */
`ifndef TB_PS2_TASKS_SVH
`define TB_PS2_TASKS_SVH

task automatic check_event(input string name, input key_event_u exp, input key_event_u act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error %s: expected brk=%0b index=%03h, actual brk=%0b index=%03h",
                 name, exp.map.brk, exp.map.index, act.map.brk, act.map.index);
    end
endtask

task automatic check_keys(input string name, input logic [KEY_MAP_W-1:0] exp,
                          input logic [KEY_MAP_W-1:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error %s: expected key_down=%h, actual key_down=%h", name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error %s: expected %0b, actual %0b", name, exp, act);
    end
endtask

// One 11-bit frame, data changes while the PS/2 clock is high
task automatic drive_frame(input logic [7:0] b, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, ~^b ^ bad_parity, b, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 11; i++) begin
        ps2_data <= bits[i];
        repeat (PS2_HALF) @(posedge clk);
        ps2_clk <= 1'b0;
        repeat (PS2_HALF) @(posedge clk);
        ps2_clk <= 1'b1;
    end
endtask

// The pipeline settles well inside the last half-period, so the map is final here
task automatic send_byte(input logic [7:0] b, input logic bad_parity);
    int fe_before;
    fe_before = fe_count;
    if (!bad_parity) begin
        model_byte(b);
    end
    drive_frame(b, bad_parity);
    repeat (FRAME_GAP) @(posedge clk);
    @(negedge clk);
    check_flag(test_name, bad_parity, fe_count != fe_before);
    if (fe_count - fe_before > 1) begin
        errors++;
        $display("%s: one frame raised %0d frame_error pulses", test_name, fe_count - fe_before);
    end
    check_keys(test_name, m_map, key_down);
endtask

// Wait until every expected event came out and every credit went back
task automatic wait_drain(input string name);
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || owed != 0 || m_credits != CREDIT_INIT) && cycles < 5000) begin
        @(posedge clk);
        cycles++;
    end
    if (exp_q.size() != 0 || owed != 0 || m_credits != CREDIT_INIT) begin
        errors++;
        $display("%s: queue did not drain, %0d events missing, %0d credits outstanding",
                 name, exp_q.size(), CREDIT_INIT - m_credits);
    end
    check_flag(name, m_overrun, overrun);
endtask

`endif

/* sim/tb_ps2_keyboard.sv */
`timescale 1ns/1ps

module tb_ps2_keyboard;
    import ps2_pkg::*;

    localparam int    PS2_HALF    = 20;
    localparam int    FRAME_GAP   = 40;
    // Worst case byte count over all tests, prefixes included
    localparam int    MAX_FRAMES  = 260;
    localparam longint WATCHDOG_NS = longint'(MAX_FRAMES) * 11 * 40 * 10 * 2 + 50_000;

    logic                 clk;
    logic                 rst;
    logic                 ps2_clk;
    logic                 ps2_data;
    logic                 credit_return;
    logic [KEY_MAP_W-1:0] key_down;
    key_event_u           out_event;
    logic                 out_valid;
    logic                 frame_error;
    logic                 overrun;

    logic [KEY_MAP_W-1:0] m_map = '0;
    logic                 m_ready = 1'b0;
    logic                 m_ext = 1'b0;
    logic                 m_brk = 1'b0;
    logic                 m_overrun = 1'b0;
    key_event_u           exp_q[$];
    int                   m_credits = CREDIT_INIT;
    int                   owed = 0;
    int                   delivered = 0;
    int                   fe_count = 0;
    int                   errors = 0;
    int                   checks = 0;
    logic                 hold_credits = 1'b0;
    string                test_name = "reset";

    ps2_keyboard_top ps2_keyboard_top_i (
        .clk           (clk),
        .rst           (rst),
        .ps2_clk       (ps2_clk),
        .ps2_data      (ps2_data),
        .key_down      (key_down),
        .out_event     (out_event),
        .out_valid     (out_valid),
        .credit_return (credit_return),
        .frame_error   (frame_error),
        .overrun       (overrun)
    );

    `include "tb_ps2_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Each cycle with out_valid high is one transfer at the next rising edge
    always @(negedge clk) begin : monitor
        key_event_u exp_ev;
        if (!rst) begin
            if (frame_error) begin
                fe_count++;
            end
            if (out_valid) begin
                if (m_credits == 0) begin
                    errors++;
                    $display("credit violation: out_valid high with no credits left");
                end
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected event on out_event, brk=%0b index=%03h",
                             out_event.map.brk, out_event.map.index);
                end else begin
                    exp_ev = exp_q.pop_front();
                    check_event(test_name, exp_ev, out_event);
                end
                delivered++;
                owed++;
                m_credits--;
            end
            if (credit_return) begin
                m_credits++;
            end
        end
    end

    // Consumer side, frees one slot some time after each event
    initial begin
        credit_return = 1'b0;
        forever begin
            wait (owed > 0 && !hold_credits);
            repeat ($urandom_range(1, 24)) @(posedge clk);
            credit_return <= 1'b1;
            owed--;
            @(posedge clk);
            credit_return <= 1'b0;
        end
    end

    task automatic model_byte(input logic [7:0] b);
        key_event_u ev;
        if (b == SCAN_INIT) begin
            m_ready = 1'b1;
            m_ext   = 1'b0;
            m_brk   = 1'b0;
        end else if (m_ready && b == SCAN_EXTEND) begin
            m_ext = 1'b1;
        end else if (m_ready && b == SCAN_BREAK) begin
            m_brk = 1'b1;
        end else if (m_ready) begin
            ev.map.brk   = m_brk;
            ev.map.index = {m_ext, b};
            m_ext = 1'b0;
            m_brk = 1'b0;
            // Only a make of an up key or a break of a down key changes anything
            if (m_map[ev.map.index] != !ev.map.brk) begin
                m_map[ev.map.index] = !ev.map.brk;
                if (exp_q.size() >= QUEUE_DEPTH) begin
                    m_overrun = 1'b1;
                end else begin
                    exp_q.push_back(ev);
                end
            end
        end
    endtask

    task automatic send_key(input logic ext, input logic brk, input logic [7:0] code);
        if (ext) begin
            send_byte(SCAN_EXTEND, 1'b0);
        end
        if (brk) begin
            send_byte(SCAN_BREAK, 1'b0);
        end
        send_byte(code, 1'b0);
    endtask

    function automatic logic [7:0] pick_code();
        return 8'(8'h10 + $urandom_range(0, 15));
    endfunction

    initial begin
        logic       ext;
        logic       brk;
        logic [7:0] code;
        int         base;
        void'($urandom(32'h5571_6e12));
        rst      = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        test_name = "pre_init";
        for (int i = 0; i < 6; i++) begin
            send_key(1'($urandom_range(0, 1)), 1'b0, pick_code());
        end
        check_keys(test_name, '0, key_down);
        wait_drain(test_name);

        test_name = "init";
        send_byte(SCAN_INIT, 1'b0);

        test_name = "random_keys";
        for (int i = 0; i < 40; i++) begin
            ext  = ($urandom_range(0, 3) == 0);
            code = pick_code();
            brk  = m_map[{ext, code}] ? ($urandom_range(0, 3) != 0) : ($urandom_range(0, 3) == 0);
            send_key(ext, brk, code);
        end
        wait_drain(test_name);

        test_name = "repeat_keys";
        for (int i = 0; i < 6; i++) begin
            ext  = 1'($urandom_range(0, 1));
            code = pick_code();
            if (!m_map[{ext, code}]) begin
                send_key(ext, 1'b0, code);
            end
            base = delivered;
            send_key(ext, 1'b0, code);
            send_key(ext, 1'b1, code);
            send_key(ext, 1'b1, code);
            if (delivered - base != 1) begin
                errors++;
                $display("%s: repeat and stray break gave %0d events instead of one",
                         test_name, delivered - base);
            end
        end
        wait_drain(test_name);

        test_name = "bad_parity";
        for (int i = 0; i < 6; i++) begin
            send_byte(pick_code(), 1'b1);
            ext  = 1'($urandom_range(0, 1));
            code = pick_code();
            send_key(ext, m_map[{ext, code}], code);
        end
        wait_drain(test_name);

        test_name = "back_pressure";
        base = delivered;
        hold_credits = 1'b1;
        for (int i = 0; i < CREDIT_INIT + QUEUE_DEPTH + 1; i++) begin
            send_key(1'($urandom_range(0, 1)), 1'b0, 8'(8'h40 + i));
            if (i == CREDIT_INIT + QUEUE_DEPTH - 1) begin
                check_flag(test_name, m_overrun, overrun);
            end
        end
        if (delivered - base != CREDIT_INIT || exp_q.size() != QUEUE_DEPTH) begin
            errors++;
            $display("%s: %0d events delivered and %0d held, wanted %0d and %0d",
                     test_name, delivered - base, exp_q.size(), CREDIT_INIT, QUEUE_DEPTH);
        end
        check_flag(test_name, m_overrun, overrun);
        hold_credits = 1'b0;
        wait_drain(test_name);
        repeat (200) @(posedge clk);
        if (delivered - base != CREDIT_INIT + QUEUE_DEPTH) begin
            errors++;
            $display("%s: held events missing after credits came back", test_name);
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+sim
src/ps2_pkg.sv
src/ps2_rx.sv
src/scan_decoder.sv
src/key_state.sv
src/key_event_queue.sv
src/ps2_keyboard_top.sv
sim/tb_ps2_keyboard.sv

/* Makefile */
SRCS = src/ps2_pkg.sv src/ps2_rx.sv src/scan_decoder.sv src/key_state.sv \
       src/key_event_queue.sv src/ps2_keyboard_top.sv \
       sim/tb_ps2_keyboard.sv sim/tb_ps2_tasks.svh

.PHONY: all run check clean

all: check

obj_dir/Vtb_ps2_keyboard: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_ps2_keyboard -f src.f

run: obj_dir/Vtb_ps2_keyboard
	./obj_dir/Vtb_ps2_keyboard > sim.log 2>&1 || true
	cat sim.log

check: run
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
